/* flist.f */
+incdir+tests
logic/mfm_pkg.sv
logic/fdc_cmd_pkg.sv
logic/mfm_data_separator.sv
logic/mfm_mark_detector.sv
logic/fdc_cmd_decode.sv
logic/fdc_field_reader.sv
logic/fdc_result_queue.sv
logic/fdc_read_top.sv
tests/tb_fdc_read.sv

/* tests/mfm_flux_model.svh */
// Included inside the testbench module after clk and flux_n; flux is ideal with integer cell periods.

bit cells[$];  // MFM cells of one field, first cell first.
bit prev_d;

// CCITT, MSB first, one byte at a time.
function automatic logic [15:0] crc_step(input logic [15:0] c, input logic [7:0] d);
    logic [15:0] r;
    r = c ^ {d, 8'h00};
    repeat (8) begin
        r = r[15] ? ((r << 1) ^ fdc_cmd_pkg::crc_poly) : (r << 1);
    end
    return r;
endfunction

function automatic void add_byte(input logic [7:0] d);
    for (int i = 7; i >= 0; i--) begin
        cells.push_back(!prev_d && !d[i]);  // clock only between two zeros.
        cells.push_back(d[i]);
        prev_d = d[i];
    end
endfunction

function automatic void add_a1_mark();
    add_byte(8'ha1);
    cells[cells.size() - 6] = 1'b0;  // drop the clock ahead of data bit 2.
endfunction

// one falling edge per one cell, held low for four clocks.
task automatic drive_flux(input int period);
    foreach (cells[i]) begin
        flux_n = !cells[i];
        repeat (4) @(posedge clk);
        #1 flux_n = 1'b1;
        repeat (period - 4) @(posedge clk);
        #1;
    end
    repeat (10 * period) @(posedge clk);  // quiet tail, detector drops framing here.
    #1;
endtask

/* tests/tb_fdc_read.sv */
// Fields carry 8 random gap bytes, 10 zero bytes and three A1 marks; faults are injected only by the testbench.
`timescale 1ns/1ps

module tb_fdc_read;

    logic                     clk;
    logic                     rstn;
    logic                     flux_n;
    logic                     cmd_valid;
    fdc_cmd_pkg::fdc_cmd_t    cmd;
    logic                     cmd_ready;
    logic                     out_valid;
    logic                     out_ready;
    fdc_cmd_pkg::rd_byte_t    out_byte;
    logic                     st_valid;
    logic                     st_ready;
    fdc_cmd_pkg::fdc_status_t st_out;

    fdc_cmd_pkg::rd_byte_t    exp_q[$];
    fdc_cmd_pkg::fdc_status_t exp_stat;
    integer                   seed = 32'h6748_14b7;
    int unsigned              cycles = 0;
    int unsigned              limit = 2000;

    `include "mfm_flux_model.svh"

    fdc_read_top dut0 (
        .clk, .rstn, .flux_n, .cmd_valid, .cmd, .cmd_ready, .out_valid, .out_ready,
        .out_byte, .st_valid, .st_ready, .st_out
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout: the read channel gave no result within %0d cycles", limit);
            abort_run();
        end
    end

    task automatic check_byte(input fdc_cmd_pkg::rd_byte_t got,
                              input fdc_cmd_pkg::rd_byte_t want, input string name);
        if (got !== want) begin
            $display("error at %0t ns: %s = %h, expected %h", $time, name, got, want);
            abort_run();
        end
    endtask

    task automatic check_status(input fdc_cmd_pkg::fdc_status_t got,
                                input fdc_cmd_pkg::fdc_status_t want, input string name);
        if (got !== want) begin
            $display("error at %0t ns: %s = %h, expected %h", $time, name, got, want);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic want, input string name);
        if (got !== want) begin
            $display("error at %0t ns: %s = %b, expected %b", $time, name, got, want);
            abort_run();
        end
    endtask

    function automatic int random_in_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // called 1 ns after a rising edge, returns at the same point.
    task automatic send_cmd(input fdc_cmd_pkg::fdc_op_e op, input logic [15:0] arg);
        cmd_valid = 1'b1;
        cmd       = '{op: op, arg: arg};
        do @(negedge clk); while (!cmd_ready);
        @(posedge clk);
        #1 cmd_valid = 1'b0;
    endtask

    // brk > 0 puts an extra edge right after data bit 7 of field byte brk.
    task automatic make_field(input int len, input bit flip, input int brk);
        logic [7:0]            field[$];
        logic [15:0]           crc;
        fdc_cmd_pkg::rd_byte_t b;
        int                    at;
        int                    pos;
        cells.delete();
        exp_q.delete();
        prev_d = 1'b0;
        repeat (8) add_byte(8'($random(seed)));
        repeat (10) add_byte(8'h00);
        crc = fdc_cmd_pkg::crc_preset;
        repeat (3) begin
            add_a1_mark();
            crc = crc_step(crc, 8'ha1);
        end
        field.push_back(8'hfb);  // data address mark.
        repeat (len) field.push_back(8'($random(seed)));
        if (brk > 0) field[brk] = field[brk] | 8'h80;
        foreach (field[i]) crc = crc_step(crc, field[i]);
        field.push_back(crc[15:8]);
        field.push_back(crc[7:0]);
        if (flip) begin
            pos        = random_in_range(1, len);
            field[pos] = field[pos] ^ (8'h01 << random_in_range(0, 7));
        end
        foreach (field[i]) begin
            at = cells.size();
            add_byte(field[i]);
            if (brk > 0 && i == brk) cells[at + 2] = 1'b1;
            b.data = field[i];
            b.last = i == field.size() - 1;
            exp_q.push_back(b);
        end
        repeat (2) add_byte(8'h4e);
        exp_stat = '{crc_ok: !flip && brk == 0, overrun: 1'b0, sync_lost: brk > 0,
                     index_seen: 1'b0, count: 16'(field.size())};
        if (brk > 0) begin
            while (exp_q.size() > brk + 1) exp_q.pop_back();
            exp_q[brk].last = 1'b1;  // the broken byte closes the field.
            exp_stat.count  = 16'(brk + 1);
        end
    endtask

    // dc_last leaves the data of the final byte unchecked.
    task automatic collect_field(input bit dc_last);
        fdc_cmd_pkg::rd_byte_t want;
        int                    idx;
        bit                    seen_last;
        idx       = 0;
        seen_last = 1'b0;
        while (!seen_last) begin
            @(negedge clk);
            check_flag(cmd_ready, 1'b0, "cmd_ready");  // field still open.
            if (st_valid) begin
                $display("status was offered before the byte marked last");
                abort_run();
            end
            if (out_valid && out_ready) begin
                if (idx >= exp_q.size()) begin
                    $display("the field gave more bytes than expected");
                    abort_run();
                end
                want = exp_q[idx];
                if (dc_last && idx == exp_q.size() - 1) want.data = out_byte.data;
                check_byte(out_byte, want, "out_byte");
                seen_last = out_byte.last;
                idx++;
            end
        end
        do @(negedge clk); while (!st_valid);
        check_status(st_out, exp_stat, "st_out");
        @(posedge clk);
        #1;
    endtask

    task automatic run_field(input int len, input int period, input bit flip, input int brk,
                             input bit stall);
        make_field(len, flip, brk);
        if (stall) begin
            while (exp_q.size() > fdc_cmd_pkg::queue_depth) exp_q.pop_back();
            exp_q[fdc_cmd_pkg::queue_depth - 1].last = 1'b1;
            exp_stat.overrun = 1'b1;
        end
        limit += (cells.size() + 10) * period;
        send_cmd(fdc_cmd_pkg::op_read_field, 16'(len));
        out_ready = !stall;
        fork
            drive_flux(period);
            begin
                if (!stall) collect_field(brk > 0);
            end
        join
        out_ready = 1'b1;
        if (stall) collect_field(1'b0);
    endtask

    initial begin
        int len;
        rstn      = 1'b0;
        flux_n    = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        out_ready = 1'b1;
        st_ready  = 1'b1;
        repeat (5) @(posedge clk);
        #1 rstn = 1'b1;
        send_cmd(fdc_cmd_pkg::op_set_rate, 16'd88);
        repeat (3) run_field(random_in_range(1, 12), 88, 1'b0, 0, 1'b0);
        run_field(random_in_range(1, 12), 88, 1'b1, 0, 1'b0);  // bad CRC.
        run_field(random_in_range(2, 12), 88, 1'b0, 0, 1'b1);  // reader outruns the queue.
        len = random_in_range(2, 12);
        run_field(len, 88, 1'b0, random_in_range(1, len), 1'b0);
        send_cmd(fdc_cmd_pkg::op_resync, 16'd0);
        run_field(random_in_range(1, 12), 88, 1'b0, 0, 1'b0);
        run_field(12, 93, 1'b0, 0, 1'b0);  // slow drive.
        run_field(12, 83, 1'b0, 0, 1'b0);  // fast drive.
        $display("Simulation passed");
        $finish;
    end

endmodule

/* logic/fdc_read_top.sv */
// Read channel only; no write path, index, seek or host bus, and commands are refused while a field is open.
`timescale 1ns/1ps

module fdc_read_top (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     flux_n,
    input  logic                     cmd_valid,
    input  fdc_cmd_pkg::fdc_cmd_t    cmd,
    output logic                     cmd_ready,
    output logic                     out_valid,
    input  logic                     out_ready,
    output fdc_cmd_pkg::rd_byte_t    out_byte,
    output logic                     st_valid,
    input  logic                     st_ready,
    output fdc_cmd_pkg::fdc_status_t st_out
);

    logic                     cell_valid;
    logic                     cell_bit;
    logic                     byte_valid;
    mfm_pkg::mfm_byte_t       rx_byte;
    logic                     clr;
    mfm_pkg::cell_len_t       cell_len;
    logic                     resync;
    logic                     start;
    logic [15:0]              field_len;
    logic                     busy;
    logic                     put_valid;
    fdc_cmd_pkg::rd_byte_t    put_byte;
    logic                     put_full;
    logic                     stat_valid;
    fdc_cmd_pkg::fdc_status_t stat;
    logic                     stat_taken;

    mfm_data_separator #(.window_track(1)) u_sep (
        .clk, .rstn, .flux_n, .cell_len, .resync, .clr,
        .cell_valid, .cell_bit, .window()
    );

    mfm_mark_detector u_mark (
        .clk, .rstn, .cell_valid, .cell_bit, .resync, .byte_valid, .rx_byte, .clr
    );

    fdc_cmd_decode u_dec (
        .clk, .rstn, .cmd_valid, .cmd, .cmd_ready, .busy, .cell_len, .resync, .start, .field_len
    );

    fdc_field_reader u_rd (
        .clk, .rstn, .start, .field_len, .byte_valid, .rx_byte, .busy, .put_valid, .put_byte,
        .put_full, .stat_valid, .stat, .stat_taken
    );

    fdc_result_queue u_q (
        .clk, .rstn, .put_valid, .put_byte, .put_full, .stat_valid, .stat, .stat_taken,
        .out_valid, .out_ready, .out_byte, .st_valid, .st_ready, .st_out
    );

endmodule

/* logic/fdc_result_queue.sv */
// Bytes put while full are dropped; a dropped last moves its flag onto the newest stored byte.
`timescale 1ns/1ps

module fdc_result_queue (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     put_valid,
    input  fdc_cmd_pkg::rd_byte_t    put_byte,
    output logic                     put_full,
    input  logic                     stat_valid,
    input  fdc_cmd_pkg::fdc_status_t stat,
    output logic                     stat_taken,
    output logic                     out_valid,
    input  logic                     out_ready,
    output fdc_cmd_pkg::rd_byte_t    out_byte,
    output logic                     st_valid,
    input  logic                     st_ready,
    output fdc_cmd_pkg::fdc_status_t st_out
);

    localparam int aw = $clog2(fdc_cmd_pkg::queue_depth);

    fdc_cmd_pkg::rd_byte_t mem [fdc_cmd_pkg::queue_depth];

    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic [aw:0]   count;
    logic          push;
    logic          pop;
    logic          st_held;
    logic          last_gone;

    assign put_full  = count == (aw + 1)'(fdc_cmd_pkg::queue_depth);
    assign push      = put_valid && !put_full;
    assign out_valid = count != '0;
    assign pop       = out_valid && out_ready;
    assign out_byte  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= put_byte;
        else if (put_valid && put_byte.last) mem[wr_ptr - 1'b1].last <= 1'b1;
        if (stat_valid && !st_held) st_out <= stat;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            st_held   <= 1'b0;
            last_gone <= 1'b0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + (push ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);
            if (pop && out_byte.last) last_gone <= 1'b1;
            if (stat_valid && !st_held) st_held <= 1'b1;
            if (stat_taken) begin
                st_held   <= 1'b0;
                last_gone <= 1'b0;
            end
        end
    end

    assign st_valid   = st_held && last_gone;  // status trails the field's last byte.
    assign stat_taken = st_valid && st_ready;

    // the pointers must hold data whenever a byte leaves.
    a_no_empty_pop: assert property (@(posedge clk) disable iff (!rstn)
        pop |-> wr_ptr != rd_ptr || count == (aw + 1)'(fdc_cmd_pkg::queue_depth));

endmodule

/* logic/fdc_field_reader.sv */
// Reads one field after the A1 marks; the CRC covers the marks, mark byte, data and both CRC bytes.
`timescale 1ns/1ps

module fdc_field_reader (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     start,
    input  logic [15:0]              field_len,
    input  logic                     byte_valid,
    input  mfm_pkg::mfm_byte_t       rx_byte,
    output logic                     busy,
    output logic                     put_valid,
    output fdc_cmd_pkg::rd_byte_t    put_byte,
    input  logic                     put_full,
    output logic                     stat_valid,
    output fdc_cmd_pkg::fdc_status_t stat,
    input  logic                     stat_taken
);

    fdc_cmd_pkg::reader_state_e state;

    logic [15:0] crc;
    logic [15:0] remain;
    logic [15:0] count;
    logic        overrun;
    logic        sync_lost;
    logic        index_seen;
    logic        take;
    logic        end_now;

    function automatic logic [15:0] crc_byte(input logic [15:0] c, input logic [7:0] d);
        logic [15:0] r;
        r = c;
        for (int i = 7; i >= 0; i--) begin
            r = {r[14:0], 1'b0} ^ ((r[15] ^ d[i]) ? fdc_cmd_pkg::crc_poly : 16'h0000);
        end
        return r;
    endfunction

    assign take = byte_valid && ((state == fdc_cmd_pkg::mark && !rx_byte.mark_a1) ||
                                 state == fdc_cmd_pkg::body);
    assign end_now = rx_byte.sync_lost || (state == fdc_cmd_pkg::body && remain == 16'd1);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= fdc_cmd_pkg::idle;
            put_valid  <= 1'b0;
            crc        <= fdc_cmd_pkg::crc_preset;
            remain     <= '0;
            count      <= '0;
            overrun    <= 1'b0;
            sync_lost  <= 1'b0;
            index_seen <= 1'b0;
        end else begin
            put_valid <= 1'b0;
            if (put_valid && put_full) overrun <= 1'b1;
            if (byte_valid && rx_byte.mark_c2 && busy && state != fdc_cmd_pkg::done)
                index_seen <= 1'b1;
            case (state)
                fdc_cmd_pkg::idle: if (start) begin
                    state      <= fdc_cmd_pkg::hunt;
                    remain     <= field_len + 16'd2;  // data plus CRC.
                    count      <= '0;
                    overrun    <= 1'b0;
                    sync_lost  <= 1'b0;
                    index_seen <= 1'b0;
                end
                fdc_cmd_pkg::hunt: if (byte_valid && rx_byte.mark_a1) begin
                    crc   <= crc_byte(fdc_cmd_pkg::crc_preset, rx_byte.data);
                    state <= fdc_cmd_pkg::mark;
                end
                fdc_cmd_pkg::mark: if (byte_valid && rx_byte.mark_a1) begin
                    crc <= crc_byte(crc, rx_byte.data);
                end
                fdc_cmd_pkg::body: if (take) remain <= remain - 1'b1;
                fdc_cmd_pkg::done: if (stat_taken) state <= fdc_cmd_pkg::idle;
                default: state <= fdc_cmd_pkg::idle;
            endcase
            if (take) begin
                put_valid <= 1'b1;
                count     <= count + 1'b1;
                crc       <= crc_byte(crc, rx_byte.data);
                state     <= end_now ? fdc_cmd_pkg::done : fdc_cmd_pkg::body;
                if (rx_byte.sync_lost) sync_lost <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            put_byte.data <= rx_byte.data;
            put_byte.last <= end_now;
        end
    end

    assign busy       = state != fdc_cmd_pkg::idle || start;
    assign stat_valid = state == fdc_cmd_pkg::done && !put_valid;  // overrun of last put settled.
    assign stat       = '{crc_ok: crc == 16'h0000 && !sync_lost, overrun: overrun,
                          sync_lost: sync_lost, index_seen: index_seen, count: count};

endmodule

/* logic/fdc_cmd_decode.sv */
// One command at a time; set_rate also restarts separator lock-in at the new cell length.
`timescale 1ns/1ps

module fdc_cmd_decode (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  cmd_valid,
    input  fdc_cmd_pkg::fdc_cmd_t cmd,
    output logic                  cmd_ready,
    input  logic                  busy,
    output mfm_pkg::cell_len_t    cell_len,
    output logic                  resync,
    output logic                  start,
    output logic [15:0]           field_len
);

    logic accept;

    assign cmd_ready = !busy;
    assign accept    = cmd_valid && cmd_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cell_len <= mfm_pkg::default_cell_len;
            resync   <= 1'b0;
            start    <= 1'b0;
        end else begin
            resync <= 1'b0;
            start  <= 1'b0;
            if (accept) begin
                case (cmd.op)
                    fdc_cmd_pkg::op_set_rate: begin
                        cell_len <= cmd.arg;
                        resync   <= 1'b1;
                    end
                    fdc_cmd_pkg::op_read_field: start  <= 1'b1;
                    fdc_cmd_pkg::op_resync:     resync <= 1'b1;
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && cmd.op == fdc_cmd_pkg::op_read_field) field_len <= cmd.arg;
    end

    a_one_pulse: assert property (@(posedge clk) disable iff (!rstn) !(start && resync));

endmodule

/* logic/mfm_mark_detector.sv */
// Bytes are framed only after an A1 or double C2 mark; a clock violation drops framing until the next mark.
`timescale 1ns/1ps

module mfm_mark_detector (
    input  logic               clk,
    input  logic               rstn,
    input  logic               cell_valid,
    input  logic               cell_bit,
    input  logic               resync,
    output logic               byte_valid,
    output mfm_pkg::mfm_byte_t rx_byte,
    output logic               clr
);

    logic [31:0] shift_q;
    logic [31:0] shift_nx;
    logic [3:0]  cell_cnt;
    logic        framed;
    logic        is_a1;
    logic        is_c2;
    logic        violation;

    assign shift_nx  = {shift_q[30:0], cell_bit};
    assign is_a1     = shift_nx[15:0] == mfm_pkg::mark_a1_pattern;
    assign is_c2     = shift_nx == mfm_pkg::mark_c2_pattern;
    assign violation = shift_nx[1:0] == 2'b11 || shift_nx[4:0] == 5'b10000;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            shift_q    <= '0;
            cell_cnt   <= '0;
            framed     <= 1'b0;
            byte_valid <= 1'b0;
            clr        <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            clr        <= 1'b0;
            if (resync) begin
                shift_q  <= '0;
                cell_cnt <= '0;
                framed   <= 1'b0;
            end else if (cell_valid) begin
                shift_q <= shift_nx;
                if (is_a1 || is_c2) begin
                    framed     <= 1'b1;
                    cell_cnt   <= '0;
                    byte_valid <= 1'b1;
                end else if (framed && violation) begin
                    framed     <= 1'b0;  // separator relocks after clr.
                    cell_cnt   <= '0;
                    byte_valid <= 1'b1;
                    clr        <= 1'b1;
                end else if (framed) begin
                    cell_cnt <= cell_cnt + 1'b1;
                    if (cell_cnt == 4'd15) byte_valid <= 1'b1;
                end
            end
        end
    end

    // data bits sit in the odd cells.
    always_ff @(posedge clk) begin
        if (cell_valid) begin
            rx_byte.data      <= {shift_nx[14], shift_nx[12], shift_nx[10], shift_nx[8],
                                  shift_nx[6], shift_nx[4], shift_nx[2], shift_nx[0]};
            rx_byte.mark_a1   <= is_a1;
            rx_byte.mark_c2   <= is_c2;
            rx_byte.sync_lost <= framed && violation && !is_a1 && !is_c2;
        end
    end

    // the two mark patterns must never overlap.
    a_one_mark: assert property (@(posedge clk) disable iff (!rstn)
        byte_valid |-> !(rx_byte.mark_a1 && rx_byte.mark_c2));

endmodule

/* logic/mfm_data_separator.sv */
// Flux input is asynchronous and synchronized here; window tracking needs cell_len of at least 8 clocks.
`timescale 1ns/1ps

module mfm_data_separator #(
    parameter int window_track = 1
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               flux_n,
    input  mfm_pkg::cell_len_t cell_len,
    input  logic               resync,
    input  logic               clr,
    output logic               cell_valid,
    output logic               cell_bit,
    output mfm_pkg::cell_len_t window
);

    localparam int sync_w = $clog2(mfm_pkg::sync_cells);

    logic [2:0]         flux_s;
    logic               flux_edge;
    logic               no_data;
    mfm_pkg::cell_len_t len_cnt;
    mfm_pkg::cell_len_t win_lo;
    mfm_pkg::cell_len_t win_hi;
    logic [sync_w-1:0]  sync_cnt;
    logic               lastd;
    logic               lasti;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            flux_s <= 3'b111;
        end else begin
            flux_s <= {flux_s[1:0], flux_n};
        end
    end

    assign flux_edge = flux_s[2] && !flux_s[1];  // falling edge after sync.
    assign win_lo = cell_len >> 1;
    assign win_hi = cell_len + (cell_len >> 1);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            no_data    <= 1'b1;
            len_cnt    <= '0;
            window     <= mfm_pkg::default_cell_len;
            sync_cnt   <= sync_w'(mfm_pkg::sync_cells - 1);
            lastd      <= 1'b0;
            lasti      <= 1'b0;
            cell_valid <= 1'b0;
            cell_bit   <= 1'b0;
        end else begin
            cell_valid <= 1'b0;
            if (resync || clr) begin
                no_data  <= 1'b1;
                window   <= cell_len;
                sync_cnt <= sync_w'(mfm_pkg::sync_cells - 1);
                lastd    <= 1'b0;
                lasti    <= 1'b0;
            end else if (no_data) begin
                if (flux_edge) begin  // first edge sets the phase.
                    len_cnt <= 16'd1;
                    no_data <= 1'b0;
                end
            end else if (flux_edge) begin
                if (sync_cnt != '0) begin
                    sync_cnt <= sync_cnt - 1'b1;
                end else begin
                    cell_valid <= 1'b1;
                    cell_bit   <= 1'b1;
                end
                // two late or two early edges in a row move the window.
                if (window_track != 0) begin
                    if (len_cnt > window) begin
                        lastd <= 1'b0;
                        lasti <= !lasti;
                        if (lasti && window < win_hi) window <= window + 1'b1;
                    end else if (len_cnt < window) begin
                        lasti <= 1'b0;
                        lastd <= !lastd;
                        if (lastd && window > win_lo) window <= window - 1'b1;
                    end else begin
                        lastd <= 1'b0;
                        lasti <= 1'b0;
                    end
                end
                len_cnt <= 16'd1;
            end else if (len_cnt == window + (window >> 1)) begin
                if (sync_cnt == '0) begin  // no edge in this cell.
                    cell_valid <= 1'b1;
                    cell_bit   <= 1'b0;
                end
                len_cnt <= (window >> 1) + 16'd1;
            end else begin
                len_cnt <= len_cnt + 1'b1;
            end
        end
    end

    // a new cell length lands together with resync, so that cycle is skipped.
    a_window_bounds: assert property (@(posedge clk) disable iff (!rstn || resync)
        window >= win_lo && window <= win_hi);

endmodule

/* logic/fdc_cmd_pkg.sv */
// Command, byte and status formats of the read channel; CRC is CCITT, MSB first, non-reflected.
package fdc_cmd_pkg;

    typedef enum logic [1:0] {
        op_set_rate   = 2'd0,
        op_read_field = 2'd1,
        op_resync     = 2'd2
    } fdc_op_e;

    typedef struct packed {
        fdc_op_e     op;
        logic [15:0] arg;  // cell length or data byte count.
    } fdc_cmd_t;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } rd_byte_t;

    typedef struct packed {
        logic        crc_ok;
        logic        overrun;
        logic        sync_lost;
        logic        index_seen;
        logic [15:0] count;  // bytes offered to the queue.
    } fdc_status_t;

    localparam int queue_depth = 4;

    localparam logic [15:0] crc_preset = 16'hffff;
    localparam logic [15:0] crc_poly   = 16'h1021;

    typedef enum logic [2:0] {
        idle,
        hunt,
        mark,
        body,
        done
    } reader_state_e;

endpackage

/* logic/mfm_pkg.sv */
// MFM line-coding constants; cell lengths are in clock cycles and marks assume standard A1/C2 sync bytes.
package mfm_pkg;

    typedef logic [15:0] cell_len_t;

    localparam cell_len_t default_cell_len = 16'd88;

    // edges ignored after a restart before cells are passed on.
    localparam int sync_cells = 40;

    // A1 with the clock between bits 4 and 5 missing.
    localparam logic [15:0] mark_a1_pattern = 16'b0100_0100_1000_1001;

    // two C2 bytes, each with a missing clock.
    localparam logic [31:0] mark_c2_pattern = 32'b0101_0010_0010_0100_0101_0010_0010_0100;

    typedef struct packed {
        logic [7:0] data;
        logic       mark_a1;
        logic       mark_c2;
        logic       sync_lost;  // framing broke on this strobe.
    } mfm_byte_t;

endpackage
